//--- hdl/rvPkg.sv
package rvPkg;

    localparam int xlen         = 32;           // data and address width
    localparam int regAddrWidth = 5;            // register index width
    localparam int regCount     = 1 << regAddrWidth;
    localparam int opcodeWidth  = 7;
    localparam logic [xlen-1:0] resetVector = '0; // first fetch address

    typedef enum logic [opcodeWidth-1:0] {
        opImm  = 7'b0010011,                    // addi, slti, shifts by imm
        op     = 7'b0110011,                    // register-register
        load   = 7'b0000011,                    // lw only
        store  = 7'b0100011,                    // sw only
        branch = 7'b1100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111                     // encoded like i-type
    } opcode_e;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immCtrl_e;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,                      // address and link math
        aluBranch = 2'b01,                      // subtract for compare
        aluFunct  = 2'b10,                      // funct3/funct7 decide
        aluPassB  = 2'b11                       // lui passes imm
    } aluOp_e;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,                     // link value
        resPcImm   = 2'b11                      // auipc
    } resultSrc_e;

    typedef enum logic [1:0] {
        pcSeq    = 2'b00,
        pcJal    = 2'b01,                       // pc + imm
        pcJalr   = 2'b10,                       // alu result, bit 0 cleared
        pcBranch = 2'b11                        // pc + imm if taken
    } pcSrc_e;

    typedef enum logic [3:0] {
        ctrlAdd   = 4'd0,
        ctrlSub   = 4'd1,
        ctrlSll   = 4'd2,
        ctrlSlt   = 4'd3,
        ctrlSltu  = 4'd4,
        ctrlXor   = 4'd5,
        ctrlSrl   = 4'd6,
        ctrlSra   = 4'd7,
        ctrlOr    = 4'd8,
        ctrlAnd   = 4'd9,
        ctrlPassB = 4'd10
    } aluCtrl_e;

    typedef struct packed {
        logic       regWrite;                   // rd gets written
        logic       memWrite;                   // store to data memory
        aluOp_e     aluOp;
        logic       aluSrc;                     // 1 selects imm as operand b
        immCtrl_e   immCtrl;
        resultSrc_e resultSrc;
        pcSrc_e     pcSrc;
    } ctrl_t;

endpackage

//--- hdl/controlUnit.sv
module controlUnit import rvPkg::*; (
    input  logic [opcodeWidth-1:0] opcode,
    output ctrl_t                  ctrl
);

    opcode_e opc;

    assign opc = opcode_e'(opcode);               // unknown codes fall to defaults

    always_comb begin
        // immediate format
        case (opc)
            opImm, load, jalr: ctrl.immCtrl = immI;
            store:             ctrl.immCtrl = immS;
            branch:            ctrl.immCtrl = immB;
            lui, auipc:        ctrl.immCtrl = immU;
            jal:               ctrl.immCtrl = immJ;
            default:           ctrl.immCtrl = immI;
        endcase

        // alu class
        case (opc)
            load, store, jalr: ctrl.aluOp = aluAdd;  // base + offset
            branch:            ctrl.aluOp = aluBranch;
            opImm, op:         ctrl.aluOp = aluFunct;
            lui:               ctrl.aluOp = aluPassB;
            default:           ctrl.aluOp = aluAdd;
        endcase

        // register write
        case (opc)
            op, opImm, load:   ctrl.regWrite = 1'b1;
            lui, auipc:        ctrl.regWrite = 1'b1;
            jal, jalr:         ctrl.regWrite = 1'b1; // link register
            default:           ctrl.regWrite = 1'b0;
        endcase

        // data memory write
        case (opc)
            store:             ctrl.memWrite = 1'b1;
            default:           ctrl.memWrite = 1'b0;
        endcase

        // operand b source
        case (opc)
            opImm, load, store: ctrl.aluSrc = 1'b1;
            jalr, lui:          ctrl.aluSrc = 1'b1;
            default:            ctrl.aluSrc = 1'b0; // op and branch use rs2
        endcase

        // writeback source
        case (opc)
            load:              ctrl.resultSrc = resMem;
            jal, jalr:         ctrl.resultSrc = resPcPlus4;
            auipc:             ctrl.resultSrc = resPcImm;
            default:           ctrl.resultSrc = resAlu;
        endcase

        // next pc class, auipc stays sequential
        case (opc)
            jal:               ctrl.pcSrc = pcJal;
            jalr:              ctrl.pcSrc = pcJalr;
            branch:            ctrl.pcSrc = pcBranch;
            default:           ctrl.pcSrc = pcSeq;
        endcase
    end

endmodule

//--- hdl/aluDecoder.sv
module aluDecoder import rvPkg::*; (
    input  aluOp_e     aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       isRegOp,                 // op opcode, not opImm
    output aluCtrl_e   aluCtrl
);

    always_comb begin
        case (aluOp)
            aluAdd:    aluCtrl = ctrlAdd;
            aluBranch: aluCtrl = ctrlSub;         // flags come along
            aluPassB:  aluCtrl = ctrlPassB;
            default: begin
                case (funct3)
                    3'b000:  aluCtrl = (isRegOp && funct7b5) ? ctrlSub : ctrlAdd;
                    3'b001:  aluCtrl = ctrlSll;
                    3'b010:  aluCtrl = ctrlSlt;
                    3'b011:  aluCtrl = ctrlSltu;
                    3'b100:  aluCtrl = ctrlXor;
                    3'b101:  aluCtrl = funct7b5 ? ctrlSra : ctrlSrl; // srai shares bit 30
                    3'b110:  aluCtrl = ctrlOr;
                    default: aluCtrl = ctrlAnd;
                endcase
            end
        endcase
    end

endmodule

//--- hdl/immGen.sv
module immGen import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  immCtrl_e        immCtrl,
    output logic [xlen-1:0] imm
);

    logic sign;

    assign sign = instr[31];                      // all formats sign from bit 31

    always_comb begin
        case (immCtrl)
            immI: imm = {{20{sign}}, instr[31:20]};
            immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{sign}}, sign, instr[7], instr[30:25],
                         instr[11:8], 1'b0};      // halfword aligned offset
            immU: imm = {instr[31:12], 12'b0};    // upper 20 bits
            immJ: imm = {{11{sign}}, sign, instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- hdl/alu.sv
module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluCtrl_e        aluCtrl,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            lessSigned,
    output logic            lessUnsigned
);

    logic [xlen-1:0] diff;
    logic [4:0]      shamt;

    assign diff         = a - b;
    assign shamt        = b[4:0];                 // low 5 bits only
    assign zero         = (diff == '0);           // a equals b
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (aluCtrl)
            ctrlAdd:   result = a + b;
            ctrlSub:   result = diff;
            ctrlSll:   result = a << shamt;
            ctrlSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
            ctrlSltu:  result = {{(xlen-1){1'b0}}, lessUnsigned};
            ctrlXor:   result = a ^ b;
            ctrlSrl:   result = a >> shamt;
            ctrlSra:   result = $unsigned($signed(a) >>> shamt); // sign fill
            ctrlOr:    result = a | b;
            ctrlAnd:   result = a & b;
            ctrlPassB: result = b;                // lui
            default:   result = '0;
        endcase
    end

endmodule

//--- hdl/regFile.sv
module regFile import rvPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] rd,
    input  logic                    writeEnable,
    input  logic [xlen-1:0]         writeData,
    output logic [xlen-1:0]         rdata1,
    output logic [xlen-1:0]         rdata2
);

    logic [xlen-1:0] regs [regCount];             // x0 slot never written

    always_ff @(posedge clk) begin
        if (!reset && writeEnable && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    // async reads, x0 hard zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/pcLogic.sv
module pcLogic import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  pcSrc_e          pcSrc,
    input  logic [2:0]      funct3,
    input  logic            zero,
    input  logic            lessSigned,
    input  logic            lessUnsigned,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] aluResult,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pcPlus4
);

    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + imm;                    // jal and branch target

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;                // beq
            3'b001:  taken = !zero;               // bne
            3'b100:  taken = lessSigned;          // blt
            3'b101:  taken = !lessSigned;         // bge
            3'b110:  taken = lessUnsigned;        // bltu
            3'b111:  taken = !lessUnsigned;       // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pcSrc)
            pcJal:    nextPc = target;
            pcJalr:   nextPc = {aluResult[xlen-1:1], 1'b0};
            pcBranch: nextPc = taken ? target : pcPlus4;
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= resetVector;
        else       pc <= nextPc;                  // one instruction per cycle
    end

endmodule

//--- hdl/rvCore.sv
module rvCore import rvPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    output logic [xlen-1:0]         pc,
    input  logic [xlen-1:0]         instr,
    output logic [xlen-1:0]         dataAddr,
    output logic                    dataWrite,
    output logic [xlen-1:0]         writeData,
    input  logic [xlen-1:0]         readData,
    output logic                    wbEnable,
    output logic [regAddrWidth-1:0] wbReg,
    output logic [xlen-1:0]         wbData
);

    ctrl_t                   ctrl;
    aluCtrl_e                aluCtrl;
    logic [regAddrWidth-1:0] rs1, rs2, rd;
    logic [2:0]              funct3;
    logic [xlen-1:0]         imm;
    logic [xlen-1:0]         rdata1, rdata2;
    logic [xlen-1:0]         srcB;
    logic [xlen-1:0]         aluResult;
    logic                    zero, lessSigned, lessUnsigned;
    logic [xlen-1:0]         pcPlus4;
    logic [xlen-1:0]         pcImm;
    logic [xlen-1:0]         result;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    controlUnit uControl (.opcode(instr[6:0]), .ctrl(ctrl));

    aluDecoder uAluDec (
        .aluOp(ctrl.aluOp), .funct3(funct3), .funct7b5(instr[30]),
        .isRegOp(!ctrl.aluSrc), .aluCtrl(aluCtrl)  // rs2 operand means op opcode
    );

    immGen uImm (.instr(instr), .immCtrl(ctrl.immCtrl), .imm(imm));

    regFile uRegs (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
        .writeEnable(ctrl.regWrite), .writeData(result),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    assign srcB = ctrl.aluSrc ? imm : rdata2;

    alu uAlu (
        .a(rdata1), .b(srcB), .aluCtrl(aluCtrl), .result(aluResult),
        .zero(zero), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned)
    );

    pcLogic uPc (
        .clk(clk), .reset(reset), .pcSrc(ctrl.pcSrc), .funct3(funct3),
        .zero(zero), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned),
        .imm(imm), .aluResult(aluResult), .pc(pc), .pcPlus4(pcPlus4)
    );

    assign pcImm = pc + imm;                      // auipc value

    always_comb begin
        case (ctrl.resultSrc)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4;
            resPcImm:   result = pcImm;
            default:    result = aluResult;
        endcase
    end

    assign dataAddr  = aluResult;
    assign writeData = rdata2;
    assign dataWrite = ctrl.memWrite && !reset;   // no stores during reset

    // trace of the write that lands at the next edge
    assign wbEnable = ctrl.regWrite && (rd != '0) && !reset;
    assign wbReg    = rd;
    assign wbData   = result;

endmodule

//--- testbench/rvCoreTb.sv
module rvCoreTb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [31:0] instr;
        string       name;
        logic        wbEn;
        logic [4:0]  wbReg;
        logic [31:0] wbData;
        logic        dw;                            // store expected
        logic [31:0] addr;
        logic [31:0] wd;
        logic [31:0] nextPc;
    } row_t;

    localparam logic [31:0] nopInstr  = 32'h0000_0013;   // addi x0, x0, 0
    localparam int          maxCycles = 200;

    logic        clk;
    logic        reset;
    logic [31:0] pc, instr, dataAddr, writeData, readData, wbData;
    logic        dataWrite, wbEnable;
    logic [4:0]  wbReg;
    logic [31:0] resetInstr;                        // fetched while reset is high

    logic [31:0] progMem [64];
    logic [31:0] dataMem [64];
    row_t        rows [$];

    rvCore uut (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr),
        .dataAddr(dataAddr), .dataWrite(dataWrite), .writeData(writeData),
        .readData(readData), .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;                     // 20 ns period
    end

    // memory models, combinational reads
    assign instr    = reset ? resetInstr
                    : (pc[31:8] == '0) ? progMem[pc[7:2]] : nopInstr;
    assign readData = dataMem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWrite) dataMem[dataAddr[7:2]] <= writeData;
    end

    // instruction encoders
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw only
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic addRow(input logic [31:0] ins, input string nm, input logic en,
                          input logic [4:0] rd, input logic [31:0] data, input logic dw,
                          input logic [31:0] addr, input logic [31:0] wd,
                          input logic [31:0] nxt);
        row_t r;
        r = '{ins, nm, en, rd, data, dw, addr, wd, nxt};
        progMem[rows.size()] = ins;                // row index is pc / 4
        rows.push_back(r);
    endtask

    task automatic addWb(input logic [31:0] ins, input string nm, input logic [4:0] rd,
                         input logic [31:0] data);
        addRow(ins, nm, 1'b1, rd, data, 1'b0, '0, '0, rows.size() * 4 + 4);
    endtask

    task automatic addBranch(input logic [31:0] ins, input string nm, input logic [31:0] nxt);
        addRow(ins, nm, 1'b0, '0, '0, 1'b0, '0, '0, nxt);
    endtask

    task automatic addFill();
        addRow(nopInstr, "skipped", 1'b0, '0, '0, 1'b0, '0, '0, rows.size() * 4 + 4);
    endtask

    task automatic buildProgram();
        for (int i = 0; i < 64; i++) begin
            progMem[i] = nopInstr;
            dataMem[i] = 32'hDA7A_0000 + i * 4;     // byte address as pattern
        end
        addWb(uType(20'h12345, 1, 7'b0110111), "lui", 1, 32'h1234_5000);        // 0
        addWb(iType(12'h678, 1, 0, 1, 7'b0010011), "addi", 1, 32'h1234_5678);   // 4
        addWb(iType(12'hFF8, 0, 0, 2, 7'b0010011), "addi neg", 2, 32'hFFFF_FFF8);
        addWb(iType(12'd1, 2, 2, 3, 7'b0010011), "slti", 3, 32'd1);             // 12
        addWb(iType(12'd1, 2, 3, 4, 7'b0010011), "sltiu", 4, 32'd0);
        addWb(iType(12'h0FF, 1, 4, 5, 7'b0010011), "xori", 5, 32'h1234_5687);   // 20
        addWb(iType(12'h00F, 2, 6, 6, 7'b0010011), "ori", 6, 32'hFFFF_FFFF);
        addWb(iType(12'h0F0, 1, 7, 7, 7'b0010011), "andi", 7, 32'h0000_0070);   // 28
        addWb(iType(12'd4, 2, 1, 8, 7'b0010011), "slli", 8, 32'hFFFF_FF80);
        addWb(iType(12'd28, 2, 5, 9, 7'b0010011), "srli", 9, 32'h0000_000F);    // 36
        addWb(iType(12'h402, 2, 5, 10, 7'b0010011), "srai", 10, 32'hFFFF_FFFE);
        addWb(rType(7'h00, 2, 1, 0, 11), "add", 11, 32'h1234_5670);             // 44
        addWb(rType(7'h20, 1, 0, 0, 12), "sub", 12, 32'hEDCB_A988);
        addWb(rType(7'h00, 6, 6, 0, 13), "add wrap", 13, 32'hFFFF_FFFE);        // 52
        addWb(rType(7'h00, 1, 2, 2, 14), "slt", 14, 32'd1);
        addWb(rType(7'h00, 1, 2, 3, 15), "sltu", 15, 32'd0);                    // 60
        addWb(rType(7'h20, 3, 2, 5, 16), "sra", 16, 32'hFFFF_FFFC);
        addWb(rType(7'h00, 3, 2, 5, 17), "srl", 17, 32'h7FFF_FFFC);             // 68
        addBranch(rType(7'h00, 1, 1, 0, 0), "write x0", 32'd76);                // no wb
        addWb(rType(7'h00, 1, 0, 0, 18), "read x0", 18, 32'h1234_5678);         // 76
        addWb(uType(20'h00001, 19, 7'b0010111), "auipc", 19, 32'h0000_1050);    // 80
        addRow(jType(21'd8, 20), "jal", 1'b1, 20, 32'd88, 1'b0, '0, '0, 32'd92);
        addFill();                                                               // 88
        addWb(iType(12'd104, 0, 0, 21, 7'b0010011), "addi base", 21, 32'd104);  // 92
        addRow(iType(12'd1, 21, 0, 22, 7'b1100111), "jalr", 1'b1, 22, 32'd100,
               1'b0, '0, '0, 32'd104);                                           // odd target
        addFill();                                                               // 100
        addBranch(bType(13'd8, 18, 1, 3'b000), "beq taken", 32'd112);           // 104
        addFill();
        addBranch(bType(13'd8, 2, 1, 3'b000), "beq not", 32'd116);              // 112
        addBranch(bType(13'd8, 2, 1, 3'b001), "bne taken", 32'd124);
        addFill();
        addBranch(bType(13'd8, 18, 1, 3'b001), "bne not", 32'd128);             // 124
        addBranch(bType(13'd8, 1, 2, 3'b100), "blt taken", 32'd136);            // -8 < pos
        addFill();
        addBranch(bType(13'd8, 2, 1, 3'b100), "blt not", 32'd140);              // 136
        addBranch(bType(13'd8, 2, 1, 3'b101), "bge taken", 32'd148);
        addFill();
        addBranch(bType(13'd8, 1, 2, 3'b101), "bge not", 32'd152);              // 148
        addBranch(bType(13'd8, 2, 1, 3'b110), "bltu taken", 32'd160);
        addFill();
        addBranch(bType(13'd8, 1, 2, 3'b110), "bltu not", 32'd164);             // 160
        addBranch(bType(13'd8, 1, 2, 3'b111), "bgeu taken", 32'd172);
        addFill();
        addBranch(bType(13'd8, 2, 1, 3'b111), "bgeu not", 32'd176);             // 172
        addRow(sType(12'd16, 1, 7), "sw", 1'b0, '0, '0, 1'b1, 32'h80,
               32'h1234_5678, 32'd180);                                          // 0x70 + 16
        addWb(iType(12'd16, 7, 2, 23, 7'b0000011), "lw", 23, 32'h1234_5678);    // 180
        addWb(iType(12'd1, 23, 0, 24, 7'b0010011), "use load", 24, 32'h1234_5679);
    endtask

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %s %s expected %h actual %h", test, field, exp, act);
            stopRun("mismatch on a DUT output");
        end
    endtask

    task automatic checkRow(input row_t r);
        checkValue(r.name, "wbEnable", 32'(r.wbEn), 32'(wbEnable));
        if (r.wbEn) begin                           // reg and data only matter on write
            checkValue(r.name, "wbReg", 32'(r.wbReg), 32'(wbReg));
            checkValue(r.name, "wbData", r.wbData, wbData);
        end
        checkValue(r.name, "dataWrite", 32'(r.dw), 32'(dataWrite));
        if (r.dw) begin
            checkValue(r.name, "dataAddr", r.addr, dataAddr);
            checkValue(r.name, "writeData", r.wd, writeData);
        end
    endtask

    initial begin
        int   idx;
        int   cycles;
        row_t r;
        logic [31:0] finalPc;

        reset      = 1'b1;
        resetInstr = sType(12'd0, 1, 0);            // sw x1, 0(x0)
        buildProgram();
        finalPc = rows.size() * 4;                  // falls off the end of the table

        for (int k = 0; k < 4; k++) begin
            #6;
            checkValue("reset", "dataWrite", 32'd0, 32'(dataWrite));
            checkValue("reset", "wbEnable", 32'd0, 32'(wbEnable));
            @(posedge clk);
            #2;
            resetInstr = k[0] ? sType(12'd0, 1, 0)
                              : uType(20'h00001, 5, 7'b0110111);  // store, then lui x5
        end
        reset = 1'b0;
        checkValue("reset", "pc", 32'd0, pc);

        cycles = 0;
        while (pc !== finalPc) begin
            if (cycles >= maxCycles) stopRun("timeout waiting for the final pc");
            @(negedge clk);
            idx = int'(pc >> 2);
            if (pc[1:0] != 2'b00 || idx >= rows.size()) begin
                stopRun($sformatf("pc %h is outside the program", pc));
            end
            r = rows[idx];
            checkRow(r);
            @(posedge clk);
            #1 checkValue(r.name, "next pc", r.nextPc, pc);
            cycles++;
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
hdl/rvPkg.sv
hdl/controlUnit.sv
hdl/aluDecoder.sv
hdl/immGen.sv
hdl/alu.sv
hdl/regFile.sv
hdl/pcLogic.sv
hdl/rvCore.sv
testbench/rvCoreTb.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: obj_dir/VrvCoreTb

obj_dir/VrvCoreTb: $(SRCS) flist.f
	verilator --binary --timing --top-module rvCoreTb -f flist.f -o VrvCoreTb

run: obj_dir/VrvCoreTb
	./obj_dir/VrvCoreTb

clean:
	rm -rf obj_dir
